//--- Bender.yml
package:
  name: core_pipeline

sources:
  - design/core_pkg.sv
  - design/core_if.sv
  - design/fetch_unit.sv
  - design/reg_file.sv
  - design/decode_unit.sv
  - design/execute_unit.sv
  - design/writeback_unit.sv
  - design/core_top.sv
  - target: test
    files:
      - verif/rv_ref_model.sv
      - verif/tb_core.sv

//--- design/core_if.sv
interface id_ex_if
    import core_pkg::*;
();

    logic                  valid;
    logic [XLEN-1:0]       pc;
    logic [XLEN-1:0]       instr;
    operation_e            op;
    logic [XLEN-1:0]       imm;
    logic [REG_ADDR_W-1:0] rs1_addr;
    logic [REG_ADDR_W-1:0] rs2_addr;
    logic [XLEN-1:0]       rs1_data;
    logic [XLEN-1:0]       rs2_data;
    logic [REG_ADDR_W-1:0] rd;
    logic                  rd_we;

    modport decode_mp (
        output valid, pc, instr, op, imm, rs1_addr, rs2_addr, rs1_data, rs2_data, rd, rd_we
    );

    modport execute_mp (
        input valid, pc, instr, op, imm, rs1_addr, rs2_addr, rs1_data, rs2_data, rd, rd_we
    );

endinterface

interface ex_wb_if
    import core_pkg::*;
();

    logic                  valid;
    logic [XLEN-1:0]       pc;
    logic [XLEN-1:0]       instr;
    logic [REG_ADDR_W-1:0] rd;
    logic                  rd_we;
    logic [XLEN-1:0]       result;

    modport execute_mp (output valid, pc, instr, rd, rd_we, result);

    modport writeback_mp (input valid, pc, instr, rd, rd_we, result);

endinterface

//--- design/core_pkg.sv
package core_pkg;

    localparam int XLEN        = 32;
    localparam int REG_ADDR_W  = 5;
    localparam int NUM_REGS    = 32;
    localparam int INSTR_BYTES = 4;

    localparam logic [XLEN-1:0] RESET_PC  = 32'h8000_0000;
    // ADDI x0, x0, 0
    localparam logic [XLEN-1:0] NOP_INSTR = 32'h0000_0013;

    // funct3 codes, shared by OP and OP_IMM
    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLL     = 3'b001;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_SLTU    = 3'b011;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_SRL_SRA = 3'b101;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;

    // funct7 selects SUB and the arithmetic shifts
    localparam logic [6:0] F7_BASE = 7'b000_0000;
    localparam logic [6:0] F7_ALT  = 7'b010_0000;

    typedef enum logic [6:0] {
        OPC_OP     = 7'b011_0011,
        OPC_OP_IMM = 7'b001_0011,
        OPC_LUI    = 7'b011_0111,
        OPC_AUIPC  = 7'b001_0111
    } opcode_e;

    typedef enum logic [4:0] {
        OP_ADD,
        OP_SUB,
        OP_SLL,
        OP_SLT,
        OP_SLTU,
        OP_XOR,
        OP_SRL,
        OP_SRA,
        OP_OR,
        OP_AND,
        OP_ADDI,
        OP_SLTI,
        OP_SLTIU,
        OP_XORI,
        OP_ORI,
        OP_ANDI,
        OP_SLLI,
        OP_SRLI,
        OP_SRAI,
        OP_LUI,
        OP_AUIPC,
        OP_UNKNOWN
    } operation_e;

    function automatic logic [XLEN-1:0] get_i_imm(input logic [XLEN-1:0] instr);
        return {{20{instr[31]}}, instr[31:20]};
    endfunction

    function automatic logic [XLEN-1:0] get_u_imm(input logic [XLEN-1:0] instr);
        return {instr[31:12], 12'b0};
    endfunction

endpackage

//--- design/core_top.sv
module core_top
    import core_pkg::*;
(
    input  logic                  clk,
    input  logic                  rstn,
    input  logic [XLEN-1:0]       imem_rdata_i,
    output logic [XLEN-1:0]       imem_addr_o,
    output logic                  retire_valid_o,
    output logic [XLEN-1:0]       retire_pc_o,
    output logic [XLEN-1:0]       retire_instr_o,
    output logic [REG_ADDR_W-1:0] retire_rd_o,
    output logic                  retire_we_o,
    output logic [XLEN-1:0]       retire_data_o
);

    logic                  if_valid;
    logic [XLEN-1:0]       if_pc;
    logic [XLEN-1:0]       if_instr;

    // Register write port, also the forwarding source
    logic                  wb_we;
    logic [REG_ADDR_W-1:0] wb_rd;
    logic [XLEN-1:0]       wb_data;

    id_ex_if id_ex ();
    ex_wb_if ex_wb ();

    fetch_unit fetch_unit_i (
        .clk          (clk),
        .rstn         (rstn),
        .imem_rdata_i (imem_rdata_i),
        .imem_addr_o  (imem_addr_o),
        .if_valid_o   (if_valid),
        .if_pc_o      (if_pc),
        .if_instr_o   (if_instr)
    );

    decode_unit decode_unit_i (
        .clk        (clk),
        .rstn       (rstn),
        .if_valid_i (if_valid),
        .if_pc_i    (if_pc),
        .if_instr_i (if_instr),
        .wb_we_i    (wb_we),
        .wb_rd_i    (wb_rd),
        .wb_data_i  (wb_data),
        .id_ex      (id_ex.decode_mp)
    );

    execute_unit execute_unit_i (
        .clk       (clk),
        .rstn      (rstn),
        .id_ex     (id_ex.execute_mp),
        .wb_we_i   (wb_we),
        .wb_rd_i   (wb_rd),
        .wb_data_i (wb_data),
        .ex_wb     (ex_wb.execute_mp)
    );

    writeback_unit writeback_unit_i (
        .clk            (clk),
        .rstn           (rstn),
        .ex_wb          (ex_wb.writeback_mp),
        .wb_we_o        (wb_we),
        .wb_rd_o        (wb_rd),
        .wb_data_o      (wb_data),
        .retire_valid_o (retire_valid_o),
        .retire_pc_o    (retire_pc_o),
        .retire_instr_o (retire_instr_o),
        .retire_rd_o    (retire_rd_o),
        .retire_we_o    (retire_we_o),
        .retire_data_o  (retire_data_o)
    );

endmodule

//--- design/decode_unit.sv
module decode_unit
    import core_pkg::*;
(
    input  logic                  clk,
    input  logic                  rstn,
    input  logic                  if_valid_i,
    input  logic [XLEN-1:0]       if_pc_i,
    input  logic [XLEN-1:0]       if_instr_i,
    input  logic                  wb_we_i,
    input  logic [REG_ADDR_W-1:0] wb_rd_i,
    input  logic [XLEN-1:0]       wb_data_i,
    id_ex_if.decode_mp            id_ex
);

    opcode_e               opcode;
    logic [2:0]            funct3;
    logic [6:0]            funct7;
    logic [REG_ADDR_W-1:0] rs1_addr;
    logic [REG_ADDR_W-1:0] rs2_addr;
    logic [XLEN-1:0]       rs1_data;
    logic [XLEN-1:0]       rs2_data;
    operation_e            op_d;
    logic [XLEN-1:0]       imm_d;

    assign opcode   = opcode_e'(if_instr_i[6:0]);
    assign funct3   = if_instr_i[14:12];
    assign funct7   = if_instr_i[31:25];
    assign rs1_addr = if_instr_i[19:15];
    assign rs2_addr = if_instr_i[24:20];

    reg_file reg_file_i (
        .clk        (clk),
        .rstn       (rstn),
        .rs1_addr_i (rs1_addr),
        .rs2_addr_i (rs2_addr),
        .wb_we_i    (wb_we_i),
        .wb_rd_i    (wb_rd_i),
        .wb_data_i  (wb_data_i),
        .rs1_data_o (rs1_data),
        .rs2_data_o (rs2_data)
    );

    always_comb begin
        op_d  = OP_UNKNOWN;
        imm_d = '0;
        case (opcode)
            OPC_LUI: begin
                op_d  = OP_LUI;
                imm_d = get_u_imm(if_instr_i);
            end
            OPC_AUIPC: begin
                op_d  = OP_AUIPC;
                imm_d = get_u_imm(if_instr_i);
            end
            OPC_OP_IMM: begin
                imm_d = get_i_imm(if_instr_i);
                case (funct3)
                    F3_ADD_SUB: op_d = OP_ADDI;
                    F3_SLT:     op_d = OP_SLTI;
                    F3_SLTU:    op_d = OP_SLTIU;
                    F3_XOR:     op_d = OP_XORI;
                    F3_OR:      op_d = OP_ORI;
                    F3_AND:     op_d = OP_ANDI;
                    F3_SLL:     op_d = (funct7 == F7_BASE) ? OP_SLLI : OP_UNKNOWN;
                    F3_SRL_SRA: begin
                        if (funct7 == F7_BASE) begin
                            op_d = OP_SRLI;
                        end else if (funct7 == F7_ALT) begin
                            op_d = OP_SRAI;
                        end
                    end
                    default: ;
                endcase
            end
            OPC_OP: begin
                if (funct7 == F7_BASE) begin
                    case (funct3)
                        F3_ADD_SUB: op_d = OP_ADD;
                        F3_SLL:     op_d = OP_SLL;
                        F3_SLT:     op_d = OP_SLT;
                        F3_SLTU:    op_d = OP_SLTU;
                        F3_XOR:     op_d = OP_XOR;
                        F3_SRL_SRA: op_d = OP_SRL;
                        F3_OR:      op_d = OP_OR;
                        F3_AND:     op_d = OP_AND;
                        default: ;
                    endcase
                end else if (funct7 == F7_ALT) begin
                    // Only SUB and SRA use the alternate funct7
                    if (funct3 == F3_ADD_SUB) begin
                        op_d = OP_SUB;
                    end else if (funct3 == F3_SRL_SRA) begin
                        op_d = OP_SRA;
                    end
                end
            end
            default: ;
        endcase
    end

    // ID/EX register
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            id_ex.valid    <= 1'b0;
            id_ex.pc       <= '0;
            id_ex.instr    <= '0;
            id_ex.op       <= OP_UNKNOWN;
            id_ex.imm      <= '0;
            id_ex.rs1_addr <= '0;
            id_ex.rs2_addr <= '0;
            id_ex.rs1_data <= '0;
            id_ex.rs2_data <= '0;
            id_ex.rd       <= '0;
            id_ex.rd_we    <= 1'b0;
        end else begin
            id_ex.valid    <= if_valid_i;
            id_ex.pc       <= if_pc_i;
            id_ex.instr    <= if_instr_i;
            id_ex.op       <= op_d;
            id_ex.imm      <= imm_d;
            id_ex.rs1_addr <= rs1_addr;
            id_ex.rs2_addr <= rs2_addr;
            id_ex.rs1_data <= rs1_data;
            id_ex.rs2_data <= rs2_data;
            id_ex.rd       <= if_instr_i[11:7];
            id_ex.rd_we    <= (op_d != OP_UNKNOWN);
        end
    end

endmodule

//--- design/execute_unit.sv
module execute_unit
    import core_pkg::*;
(
    input  logic                  clk,
    input  logic                  rstn,
    id_ex_if.execute_mp           id_ex,
    input  logic                  wb_we_i,
    input  logic [REG_ADDR_W-1:0] wb_rd_i,
    input  logic [XLEN-1:0]       wb_data_i,
    ex_wb_if.execute_mp           ex_wb
);

    logic [XLEN-1:0] op_a;
    logic [XLEN-1:0] rs2_val;
    logic [XLEN-1:0] op_b;
    logic [4:0]      shamt;

    // Forward from writeback, the instruction just ahead of this one
    assign op_a    = (wb_we_i && (wb_rd_i == id_ex.rs1_addr)) ? wb_data_i : id_ex.rs1_data;
    assign rs2_val = (wb_we_i && (wb_rd_i == id_ex.rs2_addr)) ? wb_data_i : id_ex.rs2_data;

    always_comb begin
        case (id_ex.op)
            OP_ADDI, OP_SLTI, OP_SLTIU, OP_XORI, OP_ORI, OP_ANDI,
            OP_SLLI, OP_SRLI, OP_SRAI: op_b = id_ex.imm;
            default:                   op_b = rs2_val;
        endcase
    end

    // Shift amount is the low five bits of rs2 or of the immediate
    assign shamt = op_b[4:0];

    always_comb begin
        case (id_ex.op)
            OP_ADD, OP_ADDI:   ex_wb.result = op_a + op_b;
            OP_SUB:            ex_wb.result = op_a - op_b;
            OP_SLL, OP_SLLI:   ex_wb.result = op_a << shamt;
            OP_SLT, OP_SLTI:   ex_wb.result = {{(XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
            OP_SLTU, OP_SLTIU: ex_wb.result = {{(XLEN-1){1'b0}}, op_a < op_b};
            OP_XOR, OP_XORI:   ex_wb.result = op_a ^ op_b;
            OP_SRL, OP_SRLI:   ex_wb.result = op_a >> shamt;
            OP_SRA, OP_SRAI:   ex_wb.result = $unsigned($signed(op_a) >>> shamt);
            OP_OR, OP_ORI:     ex_wb.result = op_a | op_b;
            OP_AND, OP_ANDI:   ex_wb.result = op_a & op_b;
            OP_LUI:            ex_wb.result = id_ex.imm;
            OP_AUIPC:          ex_wb.result = id_ex.pc + id_ex.imm;
            default:           ex_wb.result = '0;
        endcase
    end

    assign ex_wb.valid = id_ex.valid;
    assign ex_wb.pc    = id_ex.pc;
    assign ex_wb.instr = id_ex.instr;
    assign ex_wb.rd    = id_ex.rd;
    assign ex_wb.rd_we = id_ex.rd_we;

endmodule

//--- design/fetch_unit.sv
module fetch_unit
    import core_pkg::*;
(
    input  logic            clk,
    input  logic            rstn,
    input  logic [XLEN-1:0] imem_rdata_i,
    output logic [XLEN-1:0] imem_addr_o,
    output logic            if_valid_o,
    output logic [XLEN-1:0] if_pc_o,
    output logic [XLEN-1:0] if_instr_o
);

    logic [XLEN-1:0] pc_q;

    // Straight-line fetch, no redirect
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            pc_q <= RESET_PC;
        end else begin
            pc_q <= pc_q + INSTR_BYTES;
        end
    end

    // Memory read is combinational, so the word belongs to pc_q
    assign imem_addr_o = pc_q;

    // IF/ID register
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            if_valid_o <= 1'b0;
            if_pc_o    <= '0;
            if_instr_o <= '0;
        end else begin
            if_valid_o <= 1'b1;
            if_pc_o    <= pc_q;
            if_instr_o <= imem_rdata_i;
        end
    end

endmodule

//--- design/reg_file.sv
module reg_file
    import core_pkg::*;
(
    input  logic                  clk,
    input  logic                  rstn,
    input  logic [REG_ADDR_W-1:0] rs1_addr_i,
    input  logic [REG_ADDR_W-1:0] rs2_addr_i,
    input  logic                  wb_we_i,
    input  logic [REG_ADDR_W-1:0] wb_rd_i,
    input  logic [XLEN-1:0]       wb_data_i,
    output logic [XLEN-1:0]       rs1_data_o,
    output logic [XLEN-1:0]       rs2_data_o
);

    logic [XLEN-1:0] regs [NUM_REGS];

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_we_i) begin
            regs[wb_rd_i] <= wb_data_i;
        end
    end

    // Write-through, a result retiring now is visible to decode
    assign rs1_data_o = (wb_we_i && (wb_rd_i == rs1_addr_i)) ? wb_data_i : regs[rs1_addr_i];
    assign rs2_data_o = (wb_we_i && (wb_rd_i == rs2_addr_i)) ? wb_data_i : regs[rs2_addr_i];

endmodule

//--- design/writeback_unit.sv
module writeback_unit
    import core_pkg::*;
(
    input  logic                  clk,
    input  logic                  rstn,
    ex_wb_if.writeback_mp         ex_wb,
    output logic                  wb_we_o,
    output logic [REG_ADDR_W-1:0] wb_rd_o,
    output logic [XLEN-1:0]       wb_data_o,
    output logic                  retire_valid_o,
    output logic [XLEN-1:0]       retire_pc_o,
    output logic [XLEN-1:0]       retire_instr_o,
    output logic [REG_ADDR_W-1:0] retire_rd_o,
    output logic                  retire_we_o,
    output logic [XLEN-1:0]       retire_data_o
);

    logic                  valid_q;
    logic [XLEN-1:0]       pc_q;
    logic [XLEN-1:0]       instr_q;
    logic [REG_ADDR_W-1:0] rd_q;
    logic                  rd_we_q;
    logic [XLEN-1:0]       result_q;

    // EX/WB register
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            valid_q  <= 1'b0;
            pc_q     <= '0;
            instr_q  <= '0;
            rd_q     <= '0;
            rd_we_q  <= 1'b0;
            result_q <= '0;
        end else begin
            valid_q  <= ex_wb.valid;
            pc_q     <= ex_wb.pc;
            instr_q  <= ex_wb.instr;
            rd_q     <= ex_wb.rd;
            rd_we_q  <= ex_wb.rd_we;
            result_q <= ex_wb.result;
        end
    end

    // The only place x0 writes are filtered out
    assign wb_we_o   = valid_q && rd_we_q && (rd_q != '0);
    assign wb_rd_o   = rd_q;
    assign wb_data_o = result_q;

    assign retire_valid_o = valid_q;
    assign retire_pc_o    = pc_q;
    assign retire_instr_o = instr_q;
    assign retire_rd_o    = rd_q;
    assign retire_we_o    = wb_we_o;
    assign retire_data_o  = result_q;

endmodule

//--- project.f
design/core_pkg.sv
design/core_if.sv
design/fetch_unit.sv
design/reg_file.sv
design/decode_unit.sv
design/execute_unit.sv
design/writeback_unit.sv
design/core_top.sv
verif/rv_ref_model.sv
verif/tb_core.sv

//--- verif/rv_ref_model.sv
module rv_ref_model
    import core_pkg::*;
();

    logic [XLEN-1:0] regs [NUM_REGS];

    initial begin
        for (int i = 0; i < NUM_REGS; i++) begin
            regs[i] = '0;
        end
    end

    // Mostly x0 to x3 so that neighbouring instructions depend on each other
    function automatic logic [4:0] pick_reg();
        if ($urandom_range(3) != 0) begin
            return 5'($urandom_range(3));
        end
        return 5'($urandom_range(31));
    endfunction

    function automatic logic [11:0] pick_imm();
        case ($urandom_range(2))
            0: return 12'($urandom_range(31));
            1: return 12'hfe0 | 12'($urandom_range(31));
            default: return 12'($urandom);
        endcase
    endfunction

    function automatic logic [XLEN-1:0] random_instr();
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [2:0]  f3;
        logic [11:0] imm;
        int unsigned kind;
        rd   = pick_reg();
        rs1  = pick_reg();
        rs2  = pick_reg();
        f3   = 3'($urandom_range(7));
        imm  = pick_imm();
        kind = $urandom_range(99);
        if (kind < 40) begin
            if ((f3 == F3_ADD_SUB || f3 == F3_SRL_SRA) && $urandom_range(1) == 1) begin
                return {7'b0100000, rs2, rs1, f3, rd, 7'b0110011};
            end
            return {7'b0000000, rs2, rs1, f3, rd, 7'b0110011};
        end else if (kind < 80) begin
            if (f3 == F3_SLL) begin
                imm[11:5] = 7'b0000000;
            end else if (f3 == F3_SRL_SRA) begin
                imm[11:5] = ($urandom_range(1) == 1) ? 7'b0100000 : 7'b0000000;
            end
            return {imm, rs1, f3, rd, 7'b0010011};
        end else if (kind < 88) begin
            return {20'($urandom), rd, 7'b0110111};
        end else if (kind < 95) begin
            return {20'($urandom), rd, 7'b0010111};
        end
        // Reserved funct7 on OP, or a load opcode which this core lacks
        if ($urandom_range(1) == 1) begin
            return {7'b0000001, rs2, rs1, f3, rd, 7'b0110011};
        end
        return {imm, rs1, f3, rd, 7'b0000011};
    endfunction

    function automatic logic [XLEN-1:0] arith_shift(input logic [XLEN-1:0] a, input logic [4:0] sh);
        logic [63:0] ext;
        ext = {{32{a[31]}}, a} >> sh;
        return ext[31:0];
    endfunction

    function automatic logic [XLEN-1:0] base_alu(input logic [2:0] f3, input logic [XLEN-1:0] a,
                                                 input logic [XLEN-1:0] b);
        case (f3)
            F3_ADD_SUB: return a + b;
            F3_SLL:     return a << b[4:0];
            F3_SLT:     return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            F3_SLTU:    return (a < b) ? 32'd1 : 32'd0;
            F3_XOR:     return a ^ b;
            F3_SRL_SRA: return a >> b[4:0];
            F3_OR:      return a | b;
            default:    return a & b;
        endcase
    endfunction

    // Architectural execution of one instruction, unknown encodings give 0
    task automatic run_instr(input logic [XLEN-1:0] pc, input logic [XLEN-1:0] instr,
                             output logic we, output logic [XLEN-1:0] data);
        logic [XLEN-1:0] a;
        logic [XLEN-1:0] b;
        logic [XLEN-1:0] imm_i;
        logic [6:0]      f7;
        logic [2:0]      f3;
        logic [4:0]      rd;
        logic            known;
        a     = regs[instr[19:15]];
        b     = regs[instr[24:20]];
        imm_i = {{20{instr[31]}}, instr[31:20]};
        f7    = instr[31:25];
        f3    = instr[14:12];
        rd    = instr[11:7];
        known = 1'b1;
        data  = '0;
        case (instr[6:0])
            7'b0110011: begin
                if (f7 == 7'b0100000 && f3 == F3_ADD_SUB) begin
                    data = a - b;
                end else if (f7 == 7'b0100000 && f3 == F3_SRL_SRA) begin
                    data = arith_shift(a, b[4:0]);
                end else if (f7 == 7'b0000000) begin
                    data = base_alu(f3, a, b);
                end else begin
                    known = 1'b0;
                end
            end
            7'b0010011: begin
                if (f3 == F3_SLL && f7 != 7'b0000000) begin
                    known = 1'b0;
                end else if (f3 == F3_SRL_SRA && f7 == 7'b0100000) begin
                    data = arith_shift(a, imm_i[4:0]);
                end else if (f3 == F3_SRL_SRA && f7 != 7'b0000000) begin
                    known = 1'b0;
                end else begin
                    data = base_alu(f3, a, imm_i);
                end
            end
            7'b0110111: data = {instr[31:12], 12'b0};
            7'b0010111: data = pc + {instr[31:12], 12'b0};
            default:    known = 1'b0;
        endcase
        we = known && (rd != 5'd0);
        if (we) begin
            regs[rd] = data;
        end
    endtask

endmodule

//--- verif/tb_core.sv
module tb_core
    import core_pkg::*;
();

    localparam int CLK_PERIOD     = 20;
    localparam int RESET_CYCLES   = 8;
    localparam int NUM_INSTR      = 400;
    localparam int SEED           = 90317;
    localparam int RETIRE_LATENCY = 3;

    logic                  clk = 1'b0;
    logic                  rstn;
    logic [XLEN-1:0]       imem_rdata;
    logic [XLEN-1:0]       imem_addr;
    logic                  retire_valid;
    logic [XLEN-1:0]       retire_pc;
    logic [XLEN-1:0]       retire_instr;
    logic [REG_ADDR_W-1:0] retire_rd;
    logic                  retire_we;
    logic [XLEN-1:0]       retire_data;

    logic [XLEN-1:0] imem [NUM_INSTR];
    logic [XLEN-1:0] expected_pc;
    int              retired;
    int              active_cycles;

    core_top core_top_i (
        .clk            (clk),
        .rstn           (rstn),
        .imem_rdata_i   (imem_rdata),
        .imem_addr_o    (imem_addr),
        .retire_valid_o (retire_valid),
        .retire_pc_o    (retire_pc),
        .retire_instr_o (retire_instr),
        .retire_rd_o    (retire_rd),
        .retire_we_o    (retire_we),
        .retire_data_o  (retire_data)
    );

    rv_ref_model ref_model ();

    always #(CLK_PERIOD / 2) clk = ~clk;

    // Program words after the random block read as NOP
    function automatic logic [XLEN-1:0] fetch_word(input logic [XLEN-1:0] addr);
        logic [XLEN-1:0] offset;
        offset = addr - RESET_PC;
        if (addr < RESET_PC || offset[1:0] != 2'b00 || (offset >> 2) >= NUM_INSTR) begin
            return NOP_INSTR;
        end
        return imem[offset >> 2];
    endfunction

    task automatic check_value(input string name, input logic [XLEN-1:0] expected,
                               input logic [XLEN-1:0] actual);
        if (actual !== expected) begin
            $display("[FAIL] %s: expected %h, actual %h", name, expected, actual);
            $display("*** FAILED ***");
            $fatal(1, "Mismatch in %s", name);
        end
    endtask

    task automatic check_retire();
        logic [XLEN-1:0] instr;
        logic            exp_we;
        logic [XLEN-1:0] exp_data;
        instr = fetch_word(expected_pc);
        ref_model.run_instr(expected_pc, instr, exp_we, exp_data);
        check_value($sformatf("instr %0d pc", retired), expected_pc, retire_pc);
        check_value($sformatf("instr %0d word", retired), instr, retire_instr);
        check_value($sformatf("instr %0d rd", retired), instr[11:7], retire_rd);
        check_value($sformatf("instr %0d we", retired), exp_we, retire_we);
        check_value($sformatf("instr %0d data", retired), exp_data, retire_data);
        expected_pc = expected_pc + 4;
        retired++;
    endtask

    // Word follows the address a little after each edge
    always @(posedge clk) begin
        #2;
        imem_rdata = fetch_word(imem_addr);
    end

    // Retire valid from the fourth cycle after reset on, with no gaps
    always @(negedge clk) begin
        if (!rstn) begin
            check_value("reset retire_valid", 1'b0, retire_valid);
            check_value("reset retire_we", 1'b0, retire_we);
        end else begin
            active_cycles++;
            check_value("fetch address", RESET_PC + (active_cycles - 1) * 4, imem_addr);
            check_value("retire valid", active_cycles > RETIRE_LATENCY, retire_valid);
            if (retire_valid) begin
                check_retire();
            end
        end
    end

    initial begin
        void'($urandom(SEED));
        rstn          = 1'b0;
        imem_rdata    = NOP_INSTR;
        expected_pc   = RESET_PC;
        retired       = 0;
        active_cycles = 0;
        for (int i = 0; i < NUM_INSTR; i++) begin
            imem[i] = ref_model.random_instr();
        end
        imem_rdata = fetch_word(RESET_PC);
        repeat (RESET_CYCLES) @(posedge clk);
        #2 rstn = 1'b1;
        wait (retired == NUM_INSTR);
        $display("*** PASSED ***");
        $finish;
    end

    initial begin
        #((NUM_INSTR + 50) * CLK_PERIOD);
        $display("Timeout: only %0d of %0d instructions retired", retired, NUM_INSTR);
        $display("*** FAILED ***");
        $fatal(1, "Simulation timed out");
    end

endmodule
